// ==== spart_pkg.sv ====
package spart_pkg;

    // frame layout.
    localparam int DATA_W     = 24;
    localparam int FRAME_BITS = DATA_W + 2;

    // baud divisor, one bit period is baud + 1 cycles.
    localparam int                BAUD_W     = 16;
    localparam logic [BAUD_W-1:0] BAUD_RESET = 16'd15;

    // register map.
    localparam int                ADDR_W      = 2;
    localparam logic [ADDR_W-1:0] ADDR_TX     = 2'd0;
    localparam logic [ADDR_W-1:0] ADDR_RX     = 2'd1;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 2'd2;
    localparam logic [ADDR_W-1:0] ADDR_BAUD   = 2'd3;

    // status bit positions.
    localparam int STAT_TX_BUSY  = 0;
    localparam int STAT_RX_VALID = 1;
    localparam int STAT_OVERRUN  = 2;

    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_SHIFT,
        RX_STOP
    } rx_state_t;

endpackage

// ==== spart_baud_timer.sv ====
module spart_baud_timer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         restart,
    input  logic [spart_pkg::BAUD_W-1:0] baud,
    output logic                         mid_tick,
    output logic                         end_tick
);
    import spart_pkg::*;

    // divisor in use for the current frame.
    logic [BAUD_W-1:0] div;
    logic [BAUD_W-1:0] count;
    logic [BAUD_W-1:0] mid_point;

    // new divisor only takes hold on a restart.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            div <= BAUD_RESET;
        end else if (restart) begin
            div <= baud;
        end
    end

    // reloads itself at zero so periods run back to back.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            count <= BAUD_RESET;
        end else if (restart) begin
            count <= baud;
        end else if (count == '0) begin
            count <= div;
        end else begin
            count <= count - 1'b1;
        end
    end

    // half the divisor rounded up, i.e. baud/2 cycles after the reload.
    assign mid_point = div - (div >> 1);

    assign mid_tick = (count == mid_point);
    assign end_tick = (count == '0);

endmodule

// ==== spart_tx.sv ====
module spart_tx (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         tx_start,
    input  logic [spart_pkg::DATA_W-1:0] tx_data,
    input  logic [spart_pkg::BAUD_W-1:0] baud,
    output logic                         txd,
    output logic                         tx_busy
);
    import spart_pkg::*;

    localparam int CNT_W = $clog2(FRAME_BITS);

    tx_state_t             state;
    logic [FRAME_BITS-1:0] shift_reg;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  load;
    logic                  last_bit;
    logic                  end_tick;

    assign load     = (state == TX_IDLE) && tx_start;
    assign last_bit = (bit_cnt == CNT_W'(FRAME_BITS - 1));

    spart_baud_timer baud_timer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .restart  (load),
        .baud     (baud),
        .mid_tick (),
        .end_tick (end_tick)
    );

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_start) begin
                        state   <= TX_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                TX_SHIFT: begin
                    if (end_tick) begin
                        // stop bit has just run out.
                        if (last_bit) begin
                            state <= TX_IDLE;
                        end
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // line idles high, so the register fills with ones.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            shift_reg <= '1;
        end else if (load) begin
            shift_reg <= {1'b1, tx_data, 1'b0};
        end else if ((state == TX_SHIFT) && end_tick) begin
            shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
        end
    end

    assign txd     = shift_reg[0];
    assign tx_busy = (state == TX_SHIFT);

endmodule

// ==== spart_rx.sv ====
module spart_rx (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rxd,
    input  logic [spart_pkg::BAUD_W-1:0] baud,
    output logic [spart_pkg::DATA_W-1:0] rx_word,
    output logic                         rx_done
);
    import spart_pkg::*;

    localparam int CNT_W = $clog2(DATA_W + 1);

    rx_state_t         state;
    logic              rxd_meta;
    logic              rxd_sync;
    logic              rxd_prev;
    logic              fall;
    logic              restart;
    logic              mid_tick;
    logic [CNT_W-1:0]  bit_cnt;
    logic [DATA_W-1:0] data_reg;

    // two-flop synchronizer plus one more for edge detect.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall    = rxd_prev && !rxd_sync;
    assign restart = (state == RX_IDLE) && fall;

    spart_baud_timer baud_timer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .restart  (restart),
        .baud     (baud),
        .mid_tick (mid_tick),
        .end_tick ()
    );

    // bit_cnt 0 is the start bit, 1..DATA_W are data bits.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state   <= RX_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                RX_SHIFT: begin
                    if (mid_tick) begin
                        if ((bit_cnt == '0) && rxd_sync) begin
                            // start bit gone by mid-bit, so a glitch.
                            state <= RX_IDLE;
                        end else begin
                            if (bit_cnt == CNT_W'(DATA_W)) begin
                                state <= RX_STOP;
                            end
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (mid_tick) begin
                        state   <= RX_IDLE;
                        rx_done <= rxd_sync;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // lsb arrives first and ends up at bit 0.
    always_ff @(posedge clk) begin
        if ((state == RX_SHIFT) && mid_tick && (bit_cnt != '0)) begin
            data_reg <= {rxd_sync, data_reg[DATA_W-1:1]};
        end
    end

    assign rx_word = data_reg;

endmodule

// ==== spart_regs.sv ====
module spart_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [spart_pkg::ADDR_W-1:0] addr,
    input  logic                         wr,
    input  logic                         rd,
    input  logic [spart_pkg::DATA_W-1:0] wdata,
    output logic [spart_pkg::DATA_W-1:0] rdata,
    output logic [spart_pkg::BAUD_W-1:0] baud,
    output logic                         tx_start,
    output logic [spart_pkg::DATA_W-1:0] tx_data,
    input  logic                         tx_busy,
    input  logic                         rx_done,
    input  logic [spart_pkg::DATA_W-1:0] rx_word
);
    import spart_pkg::*;

    logic              wr_tx;
    logic              wr_baud;
    logic              rd_rx;
    logic              rd_status;
    logic              rx_valid;
    logic              overrun;
    logic [DATA_W-1:0] rx_buf;
    logic [DATA_W-1:0] status;

    // also drop a write that lands while a start pulse is in flight.
    assign wr_tx     = wr && (addr == ADDR_TX) && !tx_busy && !tx_start;
    assign wr_baud   = wr && (addr == ADDR_BAUD);
    assign rd_rx     = rd && (addr == ADDR_RX);
    assign rd_status = rd && (addr == ADDR_STATUS);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= wr_tx;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tx) begin
            tx_data <= wdata;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            baud <= BAUD_RESET;
        end else if (wr_baud) begin
            baud <= wdata[BAUD_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_buf <= rx_word;
        end
    end

    // a new word beats a read in the same cycle.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
        end else if (rd_rx) begin
            rx_valid <= 1'b0;
        end
    end

    // a word arriving while the last one still waits is an overrun.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            overrun <= 1'b0;
        end else if (rx_done && rx_valid) begin
            overrun <= 1'b1;
        end else if (rd_status) begin
            overrun <= 1'b0;
        end
    end

    always_comb begin
        status                = '0;
        status[STAT_TX_BUSY]  = tx_busy;
        status[STAT_RX_VALID] = rx_valid;
        status[STAT_OVERRUN]  = overrun;
    end

    // read data holds until the next rd.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd) begin
            case (addr)
                ADDR_RX:     rdata <= rx_buf;
                ADDR_STATUS: rdata <= status;
                ADDR_BAUD:   rdata <= DATA_W'(baud);
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

// ==== spart_top.sv ====
module spart_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [spart_pkg::ADDR_W-1:0] addr,
    input  logic                         wr,
    input  logic                         rd,
    input  logic [spart_pkg::DATA_W-1:0] wdata,
    output logic [spart_pkg::DATA_W-1:0] rdata,
    input  logic                         rxd,
    output logic                         txd
);
    import spart_pkg::*;

    logic [BAUD_W-1:0] baud;
    logic              tx_start;
    logic [DATA_W-1:0] tx_data;
    logic              tx_busy;
    logic              rx_done;
    logic [DATA_W-1:0] rx_word;

    spart_regs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .wr       (wr),
        .rd       (rd),
        .wdata    (wdata),
        .rdata    (rdata),
        .baud     (baud),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .rx_done  (rx_done),
        .rx_word  (rx_word)
    );

    // both directions share the divisor but keep their own timers.
    spart_tx tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .baud     (baud),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    spart_rx rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (rxd),
        .baud     (baud),
        .rx_word  (rx_word),
        .rx_done  (rx_done)
    );

endmodule

// ==== spart_props.sv ====
module spart_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic [spart_pkg::ADDR_W-1:0] addr,
    input logic                         wr,
    input logic                         rd,
    input logic [spart_pkg::DATA_W-1:0] rdata,
    input logic                         rxd,
    input logic                         txd,
    input logic [spart_pkg::BAUD_W-1:0] baud,
    input logic                         tx_start,
    input logic [spart_pkg::DATA_W-1:0] tx_data,
    input logic                         tx_busy,
    input logic                         rx_done,
    input logic [spart_pkg::DATA_W-1:0] rx_word
);
    import spart_pkg::*;

    localparam int BIT_W = $clog2(FRAME_BITS);

    int unsigned       fail_count = 0;
    logic              m_active;
    logic [BAUD_W-1:0] m_div;
    logic [BAUD_W-1:0] m_cyc;
    logic [BIT_W-1:0]  m_bit;
    logic [DATA_W-1:0] m_word;
    logic              loop_ok;
    logic              exp_txd;
    logic              m_valid;
    logic              m_overrun;
    logic              rd_rx;
    logic              rd_status;
    logic [DATA_W-1:0] exp_status;

    assign rd_rx      = rd && (addr == ADDR_RX);
    assign rd_status  = rd && (addr == ADDR_STATUS);
    assign exp_status = DATA_W'({m_overrun, m_valid, m_active});

    // start bit, then data lsb first, then stop bit.
    assign exp_txd = (m_bit == '0) ? 1'b0 :
                     (m_bit == BIT_W'(FRAME_BITS - 1)) ? 1'b1 :
                     m_word[m_bit - 1'b1];

    // reference frame timing, baud+1 cycles per bit.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            m_active <= 1'b0;
            m_div    <= '0;
            m_cyc    <= '0;
            m_bit    <= '0;
            m_word   <= '0;
            loop_ok  <= 1'b0;
        end else if (tx_start) begin
            m_active <= 1'b1;
            m_div    <= baud;
            m_cyc    <= '0;
            m_bit    <= '0;
            m_word   <= tx_data;
            loop_ok  <= 1'b1;
        end else begin
            if (rxd != txd) begin
                loop_ok <= 1'b0;
            end
            if (m_active && (m_cyc == m_div)) begin
                m_cyc <= '0;
                if (m_bit == BIT_W'(FRAME_BITS - 1)) begin
                    m_active <= 1'b0;
                end else begin
                    m_bit <= m_bit + 1'b1;
                end
            end else if (m_active) begin
                m_cyc <= m_cyc + 1'b1;
            end
        end
    end

    // receive flags as the host should see them.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            m_valid   <= 1'b0;
            m_overrun <= 1'b0;
        end else begin
            if (rx_done) begin
                m_valid <= 1'b1;
            end else if (rd_rx) begin
                m_valid <= 1'b0;
            end
            if (rx_done && m_valid) begin
                m_overrun <= 1'b1;
            end else if (rd_status) begin
                m_overrun <= 1'b0;
            end
        end
    end

    idle_high: assert property (@(posedge clk) disable iff (!rst_n) !m_active |-> txd)
        else begin
            $error("txd low outside a frame");
            fail_count++;
        end
    frame_bit: assert property (@(posedge clk) disable iff (!rst_n) m_active |-> txd == exp_txd)
        else begin
            $error("txd bit differs from the frame");
            fail_count++;
        end
    busy_span: assert property (@(posedge clk) disable iff (!rst_n) tx_busy == m_active)
        else begin
            $error("tx_busy does not span the frame");
            fail_count++;
        end
    start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
        else begin
            $error("tx_start while busy");
            fail_count++;
        end
    busy_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (wr && (addr == ADDR_TX) && tx_busy) |=> !tx_start)
        else begin
            $error("write while busy was not dropped");
            fail_count++;
        end
    loop_data: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_done && loop_ok) |-> rx_word == m_word)
        else begin
            $error("looped back word differs");
            fail_count++;
        end
    status_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_status |=> rdata == $past(exp_status))
        else begin
            $error("status read differs");
            fail_count++;
        end

endmodule

// ==== tb_spart.sv ====
module tb_spart;
    import spart_pkg::*;

    localparam int LOOP_WORDS = 8;
    localparam int FAST_BAUD  = 9;
    // loopback at both divisors, then busy drop, overrun and glitch at the fast one.
    localparam int TEST_CYCLES = LOOP_WORDS * FRAME_BITS * (int'(BAUD_RESET) + 1)
                               + (LOOP_WORDS + 4) * FRAME_BITS * (FAST_BAUD + 1);
    localparam int WATCHDOG_CYCLES = 3 * TEST_CYCLES;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] addr;
    logic              wr;
    logic              rd;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              rxd;
    logic              txd;
    logic              loop_en;
    logic              line_drv;
    logic [31:0]       rng;
    int                cur_baud;
    int                check_errors;
    int                assert_errors;

    assign rxd = loop_en ? txd : line_drv;

    spart_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .wr    (wr),
        .rd    (rd),
        .wdata (wdata),
        .rdata (rdata),
        .rxd   (rxd),
        .txd   (txd)
    );

    bind spart_top spart_props props_i (
        .clk (clk), .rst_n (rst_n), .addr (addr), .wr (wr), .rd (rd), .rdata (rdata),
        .rxd (rxd), .txd (txd), .baud (baud), .tx_start (tx_start), .tx_data (tx_data),
        .tx_busy (tx_busy), .rx_done (rx_done), .rx_word (rx_word)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int frame_cycles(input int b);
        return FRAME_BITS * (b + 1);
    endfunction

    task automatic next_word(output logic [DATA_W-1:0] w);
        rng = xorshift32(rng);
        w   = rng[DATA_W-1:0];
    endtask

    task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(posedge clk);
        wr    <= 1'b0;
    endtask

    // rdata is registered, so sample it half a cycle after the strobe edge.
    task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
        @(posedge clk);
        rd   <= 1'b0;
        @(negedge clk);
        d = rdata;
    endtask

    task automatic wait_rx_done(input int max_cycles, output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && (n < max_cycles)) begin
            @(negedge clk);
            seen = dut_i.rx_done;
            n++;
        end
    endtask

    task automatic expect_rx_done(input string what);
        bit seen;
        wait_rx_done(2 * frame_cycles(cur_baud), seen);
        if (!seen) begin
            $display("no received word within two frames at %0t (%s)", $time, what);
            check_errors++;
        end
    endtask

    task automatic wait_tx_idle();
        logic [DATA_W-1:0] s;
        int                polls;
        polls = 0;
        bus_read(ADDR_STATUS, s);
        while (s[STAT_TX_BUSY] && (polls < frame_cycles(cur_baud))) begin
            bus_read(ADDR_STATUS, s);
            polls++;
        end
        if (s[STAT_TX_BUSY]) begin
            $display("transmitter still busy at %0t after a whole frame", $time);
            check_errors++;
        end
    endtask

    task automatic run_loopback(input int count);
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] r;
        for (int i = 0; i < count; i++) begin
            next_word(w);
            bus_write(ADDR_TX, w);
            expect_rx_done("loopback");
            bus_read(ADDR_STATUS, r);
            check_value("rx_valid before read", DATA_W'(r[STAT_RX_VALID]), 24'd1);
            bus_read(ADDR_RX, r);
            check_value("looped back word", r, w);
            bus_read(ADDR_STATUS, r);
            check_value("rx_valid after read", DATA_W'(r[STAT_RX_VALID]), 24'd0);
            wait_tx_idle();
        end
    endtask

    initial begin
        logic [DATA_W-1:0] w1;
        logic [DATA_W-1:0] w2;
        logic [DATA_W-1:0] r;
        bit                seen;
        rst_n        = 1'b0;
        addr         = '0;
        wr           = 1'b0;
        rd           = 1'b0;
        wdata        = '0;
        loop_en      = 1'b1;
        line_drv     = 1'b1;
        rng          = 32'hb812;
        cur_baud     = int'(BAUD_RESET);
        check_errors = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("txd after reset", DATA_W'(txd), 24'd1);
        bus_read(ADDR_STATUS, r);
        check_value("status after reset", r, '0);
        bus_read(ADDR_BAUD, r);
        check_value("baud after reset", r, DATA_W'(BAUD_RESET));
        run_loopback(LOOP_WORDS);

        bus_write(ADDR_BAUD, DATA_W'(FAST_BAUD));
        cur_baud = FAST_BAUD;
        bus_read(ADDR_BAUD, r);
        check_value("baud after write", r, DATA_W'(FAST_BAUD));
        run_loopback(LOOP_WORDS);

        // second write lands while the first frame is going out.
        next_word(w1);
        next_word(w2);
        bus_write(ADDR_TX, w1);
        bus_write(ADDR_TX, w2);
        expect_rx_done("busy drop");
        bus_read(ADDR_RX, r);
        check_value("word after busy drop", r, w1);
        wait_tx_idle();

        next_word(w1);
        next_word(w2);
        bus_write(ADDR_TX, w1);
        expect_rx_done("overrun first frame");
        wait_tx_idle();
        bus_write(ADDR_TX, w2);
        expect_rx_done("overrun second frame");
        bus_read(ADDR_STATUS, r);
        check_value("overrun set", DATA_W'(r[STAT_OVERRUN]), 24'd1);
        bus_read(ADDR_RX, r);
        check_value("word after overrun", r, w2);
        bus_read(ADDR_STATUS, r);
        check_value("overrun cleared", DATA_W'(r[STAT_OVERRUN]), 24'd0);
        wait_tx_idle();

        // two cycles low, half a bit is five.
        @(posedge clk);
        loop_en <= 1'b0;
        @(posedge clk);
        line_drv <= 1'b0;
        repeat (2) @(posedge clk);
        line_drv <= 1'b1;
        wait_rx_done(frame_cycles(cur_baud), seen);
        if (seen) begin
            $display("receiver took a short glitch for a frame at %0t", $time);
            check_errors++;
        end

        repeat (4) @(posedge clk);
        assert_errors = int'(dut_i.props_i.fail_count);
        $display("register check errors: %0d, assertion errors: %0d",
                 check_errors, assert_errors);
        if ((check_errors == 0) && (assert_errors == 0)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
spart_pkg.sv
spart_baud_timer.sv
spart_tx.sv
spart_rx.sv
spart_regs.sv
spart_top.sv
spart_props.sv
tb_spart.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_spart -f sim.f -o sim_spart \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_spart +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
